// File: design/mult_if_pkg.sv
package mult_if_pkg;

    ////////////////////
    // Opcode
    ////////////////////

    // Selects the 2x2 block used in the low lanes
    typedef enum logic {
        MUL_EXACT  = 1'b0,
        MUL_APPROX = 1'b1
    } mult_op_e;

    ////////////////////
    // Request and result seen at the top level
    ////////////////////

    // Two's complement operands plus opcode, 17 bits
    typedef struct packed {
        logic signed [7:0] a;
        logic signed [7:0] b;
        mult_op_e          op;
    } mult_req_t;

    // Two's complement product
    typedef struct packed {
        logic signed [15:0] product;
    } mult_rsp_t;

endpackage

// File: design/mult_arith_pkg.sv
package mult_arith_pkg;

    import mult_if_pkg::*;

    ////////////////////
    // Datapath sizes
    ////////////////////

    // Operand width, tied to the 2-bit digit split
    localparam int OPND_W = 8;

    // 2-bit digits in the magnitude of a
    localparam int DIGITS = OPND_W / 2;

    // Digit (max 3) times magnitude (max 255) fits in 10 bits
    localparam int ROW_W = 10;

    ////////////////////
    // Internal structs
    ////////////////////

    // Sign-magnitude form of a request, 18 bits
    typedef struct packed {
        logic [DIGITS-1:0][1:0] a_digits;
        logic [OPND_W-1:0]      b_mag;
        logic                   neg;
        mult_op_e               op;
    } split_t;

    // One lane product
    typedef logic [ROW_W-1:0] row_t;

endpackage

// File: design/operand_splitter.sv
`timescale 1ns/1ps

module operand_splitter
    import mult_if_pkg::*, mult_arith_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  mult_req_t req,
    output logic      split_valid,
    output split_t    split
);

    logic [OPND_W-1:0] a_mag;
    logic [OPND_W-1:0] b_mag;
    logic              a_zero;
    logic              b_zero;
    logic              prod_neg;
    split_t            split_next;

    ////////////////////
    // Sign-magnitude conversion
    ////////////////////

    // Magnitude of -128 wraps to 8'h80, read as unsigned 128
    assign a_mag = req.a[OPND_W-1] ? (~req.a + 1'b1) : req.a;
    assign b_mag = req.b[OPND_W-1] ? (~req.b + 1'b1) : req.b;

    assign a_zero = (a_mag == '0);
    assign b_zero = (b_mag == '0);

    // Zero result always positive
    assign prod_neg = (req.a[OPND_W-1] ^ req.b[OPND_W-1]) & ~a_zero & ~b_zero;

    always_comb begin
        split_next.b_mag = b_mag;
        split_next.neg   = prod_neg;
        split_next.op    = req.op;
        // Digit i of a covers bits 2i+1:2i
        for (int i = 0; i < DIGITS; i++) begin
            split_next.a_digits[i] = a_mag[2*i +: 2];
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            split_valid <= 1'b0;
            split       <= '0;
        end else begin
            split_valid <= in_valid;
            if (in_valid) begin
                split <= split_next;
            end
        end
    end

endmodule

// File: design/digit_row_mult.sv
`timescale 1ns/1ps

module digit_row_mult
    import mult_if_pkg::*, mult_arith_pkg::*;
#(
    parameter int LANE         = 0,
    parameter int APPROX_LANES = 2
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              split_valid,
    input  logic [1:0]        digit,
    input  logic [OPND_W-1:0] b_mag,
    input  mult_op_e          op,
    output logic              row_valid,
    output row_t              row
);

    // 2-bit pieces of b_mag
    localparam int PIECES = OPND_W / 2;

    // Fixed at elaboration from the lane index
    localparam bit LANE_APPROX = (LANE < APPROX_LANES);

    logic use_approx;
    row_t row_sum;

    ////////////////////
    // 2x2 blocks
    ////////////////////

    function automatic logic [3:0] mul2x2_exact(input logic [1:0] x, input logic [1:0] y);
        logic p00;
        logic p01;
        logic p10;
        logic p11;
        logic carry;
        p00   = x[0] & y[0];
        p01   = x[0] & y[1];
        p10   = x[1] & y[0];
        p11   = x[1] & y[1];
        carry = p01 & p10;
        return {carry & p11, carry ^ p11, p01 ^ p10, p00};
    endfunction

    // K-map version, drops the carry so 3x3 gives 7
    function automatic logic [3:0] mul2x2_kmap(input logic [1:0] x, input logic [1:0] y);
        logic p00;
        logic p01;
        logic p10;
        logic p11;
        p00 = x[0] & y[0];
        p01 = x[0] & y[1];
        p10 = x[1] & y[0];
        p11 = x[1] & y[1];
        return {1'b0, p11, p01 | p10, p00};
    endfunction

    assign use_approx = (op == MUL_APPROX) && LANE_APPROX;

    // Partial products shifted by 2 bits per piece
    always_comb begin : row_build
        logic [1:0] piece;
        logic [3:0] pp;
        row_sum = '0;
        for (int j = 0; j < PIECES; j++) begin
            piece   = b_mag[2*j +: 2];
            pp      = use_approx ? mul2x2_kmap(digit, piece) : mul2x2_exact(digit, piece);
            row_sum = row_sum + (ROW_W'(pp) << (2*j));
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            row_valid <= 1'b0;
            row       <= '0;
        end else begin
            row_valid <= split_valid;
            if (split_valid) begin
                row <= row_sum;
            end
        end
    end

endmodule

// File: design/row_accumulator.sv
`timescale 1ns/1ps

module row_accumulator
    import mult_if_pkg::*, mult_arith_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              row_valid,
    input  row_t [DIGITS-1:0] rows,
    input  logic              neg,
    output logic              out_valid,
    output mult_rsp_t         rsp
);

    localparam int PROD_W = 2 * OPND_W;

    logic              neg_q;
    logic [PROD_W-1:0] mag;
    logic [PROD_W-1:0] prod_next;

    ////////////////////
    // Sign alignment
    ////////////////////

    // Sign leaves the splitter one cycle ahead of the rows
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            neg_q <= 1'b0;
        end else begin
            neg_q <= neg;
        end
    end

    ////////////////////
    // Shift-add of rows
    ////////////////////

    always_comb begin
        mag = '0;
        // Row i weighted by 4**i
        for (int i = 0; i < DIGITS; i++) begin
            mag = mag + (PROD_W'(rows[i]) << (2*i));
        end
    end

    // Back to two's complement
    assign prod_next = neg_q ? (~mag + 1'b1) : mag;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            rsp       <= '0;
        end else begin
            out_valid <= row_valid;
            if (row_valid) begin
                rsp.product <= prod_next;
            end
        end
    end

endmodule

// File: design/approx_mult_top.sv
`timescale 1ns/1ps

module approx_mult_top
    import mult_if_pkg::*, mult_arith_pkg::*;
#(
    parameter int APPROX_LANES = 2
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      in_valid,
    input  mult_req_t req,
    output logic      out_valid,
    output mult_rsp_t rsp
);

    logic              split_valid;
    split_t            split;
    logic [DIGITS-1:0] lane_valid;
    row_t [DIGITS-1:0] rows;

    // Lane count limits the approximate range
    if (APPROX_LANES < 0 || APPROX_LANES > DIGITS) begin : g_bad_param
        $error("APPROX_LANES out of range");
    end

    operand_splitter u_splitter (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .req         (req),
        .split_valid (split_valid),
        .split       (split)
    );

    ////////////////////
    // Lanes, one per digit of a
    ////////////////////

    for (genvar i = 0; i < DIGITS; i++) begin : g_lane
        digit_row_mult #(
            .LANE         (i),
            .APPROX_LANES (APPROX_LANES)
        ) u_lane (
            .clk         (clk),
            .rst_n       (rst_n),
            .split_valid (split_valid),
            .digit       (split.a_digits[i]),
            .b_mag       (split.b_mag),
            .op          (split.op),
            .row_valid   (lane_valid[i]),
            .row         (rows[i])
        );
    end

    // All lanes run in step, lane 0 stands for them
    row_accumulator u_accum (
        .clk       (clk),
        .rst_n     (rst_n),
        .row_valid (lane_valid[0]),
        .rows      (rows),
        .neg       (split.neg),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

endmodule

// File: dv/approx_mult_asserts.sv
`timescale 1ns/1ps

module approx_mult_asserts
    import mult_if_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input logic      in_valid,
    input mult_req_t req,
    input logic      out_valid,
    input mult_rsp_t rsp
);

    logic zero_req;

    // Strobe carrying a zero operand
    assign zero_req = in_valid && ((req.a == '0) || (req.b == '0));

    ////////////////////
    // Latency
    ////////////////////

    a_latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |-> ##3 out_valid)
        else $error("out_valid missing 3 cycles after in_valid");

    a_latency_back: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> $past(in_valid, 3))
        else $error("out_valid without in_valid 3 cycles earlier");

    ////////////////////
    // Reset and zero operands
    ////////////////////

    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !out_valid)
        else $error("out_valid high after a reset cycle");

    a_zero_product: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && $past(zero_req, 3)) |-> (rsp.product == '0))
        else $error("nonzero product for a zero operand");

endmodule

bind approx_mult_top approx_mult_asserts u_asserts (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .rsp       (rsp)
);

// File: dv/approx_mult_tb.sv
`timescale 1ns/1ps

module approx_mult_tb
    import mult_if_pkg::*;
;

    localparam int  APPROX_LANES = 2;
    localparam int  TABLE_LEN    = 17;
    localparam int  N_RANDOM     = 200;
    localparam real CLK_PERIOD   = 40.0;

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    mult_req_t req;
    logic      out_valid;
    mult_rsp_t rsp;

    // Directed table
    string                tbl_name [TABLE_LEN];
    logic signed [7:0]    tbl_a    [TABLE_LEN];
    logic signed [7:0]    tbl_b    [TABLE_LEN];
    mult_op_e             tbl_op   [TABLE_LEN];
    logic signed [15:0]   tbl_exp  [TABLE_LEN];

    // Requests in flight, oldest first
    logic signed [15:0] exp_q[$];
    string              name_q[$];
    int                 due_q[$];

    // Rising edges seen so far
    int cycle_cnt;

    int mismatch_count;
    int other_count;

    approx_mult_top #(
        .APPROX_LANES (APPROX_LANES)
    ) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .rsp       (rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    ////////////////////
    // Reference model
    ////////////////////

    // Digit rule: 3x3 gives 7 in low lanes when approximate
    function automatic logic signed [15:0] ref_product(input logic signed [7:0] a,
                                                       input logic signed [7:0] b,
                                                       input mult_op_e op);
        int a_mag;
        int b_mag;
        int d;
        int p;
        int pp;
        int mag;
        a_mag = (a < 0) ? -int'(a) : int'(a);
        b_mag = (b < 0) ? -int'(b) : int'(b);
        mag   = 0;
        for (int i = 0; i < 4; i++) begin
            d = (a_mag >> (2 * i)) & 3;
            for (int j = 0; j < 4; j++) begin
                p  = (b_mag >> (2 * j)) & 3;
                pp = d * p;
                if (op == MUL_APPROX && i < APPROX_LANES && d == 3 && p == 3) begin
                    pp = 7;
                end
                mag = mag + (pp << (2 * (i + j)));
            end
        end
        if (((a < 0) != (b < 0)) && a_mag != 0 && b_mag != 0) begin
            return -mag;
        end
        return mag;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    ////////////////////
    // Stimulus helpers
    ////////////////////

    task automatic set_entry(input int idx, input string name, input logic signed [7:0] a,
                             input logic signed [7:0] b, input mult_op_e op,
                             input logic signed [15:0] expv);
        tbl_name[idx] = name;
        tbl_a[idx]    = a;
        tbl_b[idx]    = b;
        tbl_op[idx]   = op;
        tbl_exp[idx]  = expv;
    endtask

    // Expected products worked out by hand from the digit rule
    task automatic fill_table();
        set_entry(0,  "exact_small",     5,    7,    MUL_EXACT,  35);
        set_entry(1,  "exact_mixed",     -12,  11,   MUL_EXACT,  -132);
        set_entry(2,  "exact_min_min",   -128, -128, MUL_EXACT,  16384);
        set_entry(3,  "exact_min_max",   -128, 127,  MUL_EXACT,  -16256);
        set_entry(4,  "exact_max_max",   127,  127,  MUL_EXACT,  16129);
        set_entry(5,  "exact_3x3",       3,    3,    MUL_EXACT,  9);
        set_entry(6,  "approx_3x3",      3,    3,    MUL_APPROX, 7);
        set_entry(7,  "approx_lane1",    12,   3,    MUL_APPROX, 28);
        set_entry(8,  "approx_lane2",    48,   3,    MUL_APPROX, 144);
        set_entry(9,  "approx_lane3",    -64,  3,    MUL_APPROX, -192);
        set_entry(10, "approx_15x15",    -15,  15,   MUL_APPROX, -175);
        set_entry(11, "approx_2x3",      2,    3,    MUL_APPROX, 6);
        set_entry(12, "zero_exact",      0,    -128, MUL_EXACT,  0);
        set_entry(13, "zero_approx",     -128, 0,    MUL_APPROX, 0);
        set_entry(14, "approx_min_min",  -128, -128, MUL_APPROX, 16384);
        set_entry(15, "approx_127_m1",   127,  -1,   MUL_APPROX, -127);
        set_entry(16, "approx_neg_neg",  -3,   -3,   MUL_APPROX, 7);
    endtask

    // One strobe per call, so calls in a row go back to back
    task automatic send_request(input mult_req_t r, input string name,
                                input logic signed [15:0] expv);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        req      = r;
        exp_q.push_back(expv);
        name_q.push_back(name);
        // Result due 3 edges after the one that samples the strobe
        due_q.push_back(cycle_cnt + 3);
    endtask

    ////////////////////
    // Checker
    ////////////////////

    always @(negedge clk) begin
        logic signed [15:0] expv;
        string              name;
        int                 due;
        if (!rst_n) begin
            if (out_valid === 1'b1) begin
                other_count++;
                $display("out_valid is high while reset is asserted");
            end
        end else if (out_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                other_count++;
                $display("out_valid is high with no request pending at %0t", $time);
            end else begin
                expv = exp_q.pop_front();
                name = name_q.pop_front();
                due  = due_q.pop_front();
                if (cycle_cnt != due) begin
                    other_count++;
                    $display("Result for %s came at cycle %0d instead of cycle %0d",
                             name, cycle_cnt, due);
                end
                if (rsp.product !== expv) begin
                    mismatch_count++;
                    $display("** Error [%s] expected %0d, actual %0d", name, expv,
                             rsp.product);
                end
            end
        end
    end

    // Watchdog
    initial begin
        #((TABLE_LEN + N_RANDOM + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [31:0] rng;
        mult_req_t   r;
        clk            = 1'b0;
        rst_n          = 1'b0;
        in_valid       = 1'b0;
        req            = '0;
        cycle_cnt      = 0;
        mismatch_count = 0;
        other_count    = 0;
        rng            = 32'hce65;
        fill_table();

        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // Idle cycles, out_valid must stay low
        repeat (2) @(posedge clk);

        for (int k = 0; k < TABLE_LEN; k++) begin
            r.a  = tbl_a[k];
            r.b  = tbl_b[k];
            r.op = tbl_op[k];
            send_request(r, tbl_name[k], tbl_exp[k]);
        end

        for (int k = 0; k < N_RANDOM; k++) begin
            rng  = lcg_next(rng);
            r.a  = rng[31:24];
            r.b  = rng[23:16];
            r.op = mult_op_e'(rng[15]);
            send_request(r, $sformatf("rand_%0d", k), ref_product(r.a, r.b, r.op));
        end

        @(posedge clk);
        #2;
        in_valid = 1'b0;
        req      = '0;

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);

        $display("Errors: %0d value mismatches, %0d other failures",
                 mismatch_count, other_count);
        if (mismatch_count + other_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: approx_mult_top.f
design/mult_if_pkg.sv
design/mult_arith_pkg.sv
design/operand_splitter.sv
design/digit_row_mult.sv
design/row_accumulator.sv
design/approx_mult_top.sv
dv/approx_mult_asserts.sv
dv/approx_mult_tb.sv
